//--- rtl/aud_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module aud_ctrl
    import aud_pkg::*;
#(
    parameter int DEPTH = DEF_DEPTH
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_key_rec,
    input  logic              i_key_play,
    input  logic              i_key_pause,
    input  logic              i_key_stop,
    xport_if.controller       rec_xp,
    xport_if.controller       play_xp,
    output logic              o_recording,
    output logic              o_playing,
    output logic              o_paused,
    output logic [ADDR_W-1:0] o_rec_len
);

    xport_state_t      state_r;
    xport_state_t      state_w;
    logic              rec_act_d_r;
    logic              play_act_d_r;
    logic [ADDR_W-1:0] rec_len_r;
    logic              rec_full;
    logic              rec_fell;
    logic              play_fell;

    assign rec_full  = (rec_xp.count == ADDR_W'(DEPTH));
    assign rec_fell  = rec_act_d_r & ~rec_xp.active;
    assign play_fell = play_act_d_r & ~play_xp.active;   // last word sent

    always_comb begin
        state_w       = state_r;
        rec_xp.start  = 1'b0;
        rec_xp.pause  = 1'b0;
        rec_xp.stop   = 1'b0;
        play_xp.start = 1'b0;
        play_xp.pause = 1'b0;
        play_xp.stop  = 1'b0;
        case (state_r)
            IDLE: begin
                if (i_key_rec) begin
                    state_w      = RECORD;
                    rec_xp.start = 1'b1;
                end else if (i_key_play) begin
                    state_w       = PLAY;
                    play_xp.start = 1'b1;
                end
            end
            RECORD, PAUSE_REC: begin
                if (i_key_stop || (state_r == RECORD && rec_full)) begin
                    state_w     = IDLE;
                    rec_xp.stop = 1'b1;
                end else if (i_key_pause) begin
                    state_w      = (state_r == RECORD) ? PAUSE_REC : RECORD;
                    rec_xp.pause = 1'b1;
                end
            end
            PLAY, PAUSE_PLAY: begin
                if (i_key_stop) begin
                    state_w      = IDLE;
                    play_xp.stop = 1'b1;
                end else if (play_fell) begin
                    state_w = IDLE;
                end else if (i_key_pause) begin
                    state_w       = (state_r == PLAY) ? PAUSE_PLAY : PLAY;
                    play_xp.pause = 1'b1;
                end
            end
            default: state_w = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r      <= IDLE;
            rec_act_d_r  <= 1'b0;
            play_act_d_r <= 1'b0;
            rec_len_r    <= '0;
        end else begin
            state_r      <= state_w;
            rec_act_d_r  <= rec_xp.active;
            play_act_d_r <= play_xp.active;
            if (rec_fell) begin
                rec_len_r <= rec_xp.count;   // count is frozen once the recorder is idle
            end
        end
    end

    assign o_recording = (state_r == RECORD) || (state_r == PAUSE_REC);
    assign o_playing   = (state_r == PLAY) || (state_r == PAUSE_PLAY);
    assign o_paused    = (state_r == PAUSE_REC) || (state_r == PAUSE_PLAY);
    assign o_rec_len   = rec_len_r;

    a_one_engine : assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        !(rec_xp.active && play_xp.active)
    ) else $error("recorder and player active together");

endmodule

`default_nettype wire

//--- rtl/aud_pkg.sv
`default_nettype none

package aud_pkg;

    localparam int SAMPLE_W  = 16;
    localparam int ADDR_W    = 20;
    localparam int BIT_W     = $clog2(SAMPLE_W);   // bit counter within a slot
    localparam int DEF_DEPTH = 1024000;

    typedef enum logic [2:0] {
        IDLE,
        RECORD,
        PLAY,
        PAUSE_REC,
        PAUSE_PLAY
    } xport_state_t;

endpackage

`default_nettype wire

//--- rtl/aud_player.sv
`timescale 1ns/1ps
`default_nettype none

module aud_player
    import aud_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_daclrck,
    input  logic [ADDR_W-1:0] i_play_len,
    output logic              o_dacdat,
    xport_if.engine           xp,
    mem_req_if.client         mem
);

    logic                playing_r;
    logic                paused_r;
    logic                lrc_d_r;
    logic                req_r;
    logic [ADDR_W-1:0]   fetch_addr_r;
    logic [ADDR_W-1:0]   count_r;
    logic                buf_valid_r;
    logic [SAMPLE_W-1:0] buf_r;     // prefetched word
    logic [SAMPLE_W-1:0] shift_r;
    logic [BIT_W-1:0]    bits_left_r;
    logic                dac_fall;
    logic                done;
    logic                fetch_go;
    logic                load;

    assign dac_fall = lrc_d_r & ~i_daclrck;
    assign done     = playing_r && (count_r == i_play_len) && (bits_left_r == '0);
    assign fetch_go = playing_r && !buf_valid_r && !req_r && !mem.ack
                      && (fetch_addr_r != i_play_len);
    // underrun leaves the slot at zero and the word goes out next frame
    assign load     = playing_r && !xp.stop && !done && dac_fall
                      && buf_valid_r && !paused_r;

    assign mem.req   = req_r;
    assign mem.we    = 1'b0;
    assign mem.addr  = fetch_addr_r;
    assign mem.wdata = '0;

    assign xp.active = playing_r;
    assign xp.count  = count_r;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            playing_r    <= 1'b0;
            paused_r     <= 1'b0;
            lrc_d_r      <= 1'b0;
            req_r        <= 1'b0;
            fetch_addr_r <= '0;
            count_r      <= '0;
            buf_valid_r  <= 1'b0;
            bits_left_r  <= '0;
            o_dacdat     <= 1'b0;
        end else begin
            lrc_d_r <= i_daclrck;

            if (req_r && mem.ack) begin
                req_r        <= 1'b0;
                buf_valid_r  <= 1'b1;
                fetch_addr_r <= fetch_addr_r + 1'b1;
            end else if (fetch_go) begin
                req_r <= 1'b1;
            end

            if (xp.start) begin
                playing_r    <= 1'b1;
                paused_r     <= 1'b0;
                buf_valid_r  <= 1'b0;
                fetch_addr_r <= '0;
                count_r      <= '0;
                bits_left_r  <= '0;
                o_dacdat     <= 1'b0;
            end else if (playing_r && (xp.stop || done)) begin
                playing_r   <= 1'b0;
                bits_left_r <= '0;
                o_dacdat    <= 1'b0;
            end else if (playing_r) begin
                if (xp.pause) begin
                    paused_r <= ~paused_r;
                end
                if (load) begin
                    o_dacdat    <= buf_r[SAMPLE_W-1];   // first bit one clock after lr edge
                    bits_left_r <= BIT_W'(SAMPLE_W - 1);
                    buf_valid_r <= 1'b0;
                    count_r     <= count_r + 1'b1;
                end else if (bits_left_r != '0) begin
                    o_dacdat    <= shift_r[SAMPLE_W-1];
                    bits_left_r <= bits_left_r - 1'b1;
                end else begin
                    o_dacdat <= 1'b0;   // right slot and idle time
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_r && mem.ack) begin
            buf_r <= mem.rdata;
        end
        if (load) begin
            shift_r <= {buf_r[SAMPLE_W-2:0], 1'b0};
        end else begin
            shift_r <= {shift_r[SAMPLE_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- rtl/aud_recorder.sv
`timescale 1ns/1ps
`default_nettype none

module aud_recorder
    import aud_pkg::*;
#(
    parameter int DEPTH = DEF_DEPTH
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_adclrck,
    input  logic      i_adcdat,
    xport_if.engine   xp,
    mem_req_if.client mem
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT,
        R_SHIFT
    } rec_state_t;

    rec_state_t          state_r;
    logic                lrc_d_r;
    logic                paused_r;
    logic [BIT_W-1:0]    bit_cnt_r;
    logic [SAMPLE_W-2:0] shift_r;
    logic [SAMPLE_W-1:0] wdata_r;
    logic                req_r;
    logic [ADDR_W-1:0]   count_r;
    logic                lrc_fall;
    logic                busy;
    logic                at_limit;
    logic                last_bit;

    assign lrc_fall = lrc_d_r & ~i_adclrck;   // left slot starts
    assign busy     = req_r | mem.ack;        // handshake not finished yet
    assign at_limit = (count_r == ADDR_W'(DEPTH));
    assign last_bit = (bit_cnt_r == BIT_W'(SAMPLE_W - 1));

    assign mem.req   = req_r;
    assign mem.we    = 1'b1;
    assign mem.addr  = count_r;   // next sequential word
    assign mem.wdata = wdata_r;

    assign xp.active = (state_r != R_IDLE);
    assign xp.count  = count_r;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r   <= R_IDLE;
            lrc_d_r   <= 1'b0;
            paused_r  <= 1'b0;
            bit_cnt_r <= '0;
            req_r     <= 1'b0;
            count_r   <= '0;
        end else begin
            lrc_d_r <= i_adclrck;

            if (req_r && mem.ack) begin
                req_r <= 1'b0;
                if (state_r != R_IDLE) begin
                    count_r <= count_r + 1'b1;   // late write after stop is not counted
                end
            end

            if (state_r == R_IDLE) begin
                if (xp.start) begin
                    state_r  <= R_WAIT;
                    paused_r <= 1'b0;
                    count_r  <= '0;
                end
            end else if (xp.stop || at_limit) begin
                state_r <= R_IDLE;
            end else begin
                if (xp.pause) begin
                    paused_r <= ~paused_r;
                end
                if (state_r == R_WAIT) begin
                    // a frame is skipped while paused or while the last write is open
                    if (lrc_fall && !paused_r && !busy) begin
                        state_r   <= R_SHIFT;
                        bit_cnt_r <= '0;
                    end
                end else begin
                    bit_cnt_r <= bit_cnt_r + 1'b1;
                    if (last_bit) begin
                        req_r   <= 1'b1;
                        state_r <= R_WAIT;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == R_SHIFT) begin
            shift_r <= {shift_r[SAMPLE_W-3:0], i_adcdat};   // msb first
            if (last_bit) begin
                wdata_r <= {shift_r, i_adcdat};
            end
        end
    end

    // req held with addr and wdata stable until the port acknowledges
    a_req_held : assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        mem.req && !mem.ack |=> mem.req && $stable(mem.addr) && $stable(mem.wdata)
    ) else $error("recorder dropped req or changed the write before ack");

endmodule

`default_nettype wire

//--- rtl/aud_top.sv
`timescale 1ns/1ps
`default_nettype none

module aud_top
    import aud_pkg::*;
#(
    parameter int DEPTH = DEF_DEPTH
) (
    input  logic                i_clk,      // codec bit clock
    input  logic                i_rst_n,
    input  logic                i_adclrck,
    input  logic                i_adcdat,
    input  logic                i_daclrck,
    output logic                o_dacdat,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic [SAMPLE_W-1:0] o_sram_wdata,
    input  logic [SAMPLE_W-1:0] i_sram_rdata,
    output logic                o_sram_we_n,
    output logic                o_sram_oe_n,
    input  logic                i_key_rec,
    input  logic                i_key_play,
    input  logic                i_key_pause,
    input  logic                i_key_stop,
    output logic                o_recording,
    output logic                o_playing,
    output logic                o_paused,
    output logic [ADDR_W-1:0]   o_rec_len
);

    mem_req_if rec_mem ();
    mem_req_if play_mem ();
    xport_if   rec_xp ();
    xport_if   play_xp ();

    aud_ctrl #(
        .DEPTH(DEPTH)
    ) u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_key_rec   (i_key_rec),
        .i_key_play  (i_key_play),
        .i_key_pause (i_key_pause),
        .i_key_stop  (i_key_stop),
        .rec_xp      (rec_xp.controller),
        .play_xp     (play_xp.controller),
        .o_recording (o_recording),
        .o_playing   (o_playing),
        .o_paused    (o_paused),
        .o_rec_len   (o_rec_len)
    );

    aud_recorder #(
        .DEPTH(DEPTH)
    ) u_recorder (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_adclrck (i_adclrck),
        .i_adcdat  (i_adcdat),
        .xp        (rec_xp.engine),
        .mem       (rec_mem.client)
    );

    aud_player u_player (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_daclrck  (i_daclrck),
        .i_play_len (o_rec_len),   // plays back the last recording
        .o_dacdat   (o_dacdat),
        .xp         (play_xp.engine),
        .mem        (play_mem.client)
    );

    sram_port u_sram_port (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .rec          (rec_mem.port),
        .play         (play_mem.port),
        .o_sram_addr  (o_sram_addr),
        .o_sram_wdata (o_sram_wdata),
        .o_sram_we_n  (o_sram_we_n),
        .o_sram_oe_n  (o_sram_oe_n),
        .i_sram_rdata (i_sram_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if
    import aud_pkg::*;
();

    logic                req;
    logic                ack;
    logic                we;      // 1 for write, 0 for read
    logic [ADDR_W-1:0]   addr;
    logic [SAMPLE_W-1:0] wdata;
    logic [SAMPLE_W-1:0] rdata;   // valid while ack is high

    modport client (
        output req, we, addr, wdata,
        input  ack, rdata
    );

    modport port (
        input  req, we, addr, wdata,
        output ack, rdata
    );

endinterface

`default_nettype wire

//--- rtl/sram_port.sv
`timescale 1ns/1ps
`default_nettype none

module sram_port
    import aud_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    mem_req_if.port             rec,
    mem_req_if.port             play,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic [SAMPLE_W-1:0] o_sram_wdata,
    output logic                o_sram_we_n,
    output logic                o_sram_oe_n,
    input  logic [SAMPLE_W-1:0] i_sram_rdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_STROBE,
        S_ACK
    } port_state_t;

    port_state_t         state_r;
    logic                sel_r;      // player is being served
    logic                ack_r;
    logic [SAMPLE_W-1:0] rdata_r;
    logic                pick_play;
    logic                pick_we;
    logic                cur_req;

    assign pick_play = ~rec.req;   // recorder has priority
    assign pick_we   = pick_play ? play.we : rec.we;
    assign cur_req   = sel_r ? play.req : rec.req;

    assign rec.ack    = ack_r & ~sel_r;
    assign play.ack   = ack_r & sel_r;
    assign rec.rdata  = rdata_r;
    assign play.rdata = rdata_r;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r     <= S_IDLE;
            sel_r       <= 1'b0;
            ack_r       <= 1'b0;
            o_sram_we_n <= 1'b1;
            o_sram_oe_n <= 1'b1;
        end else begin
            case (state_r)
                S_IDLE: begin
                    if (rec.req || play.req) begin
                        sel_r       <= pick_play;
                        o_sram_we_n <= ~pick_we;
                        o_sram_oe_n <= pick_we;
                        state_r     <= S_STROBE;
                    end
                end
                S_STROBE: begin   // strobe low for exactly one cycle
                    o_sram_we_n <= 1'b1;
                    o_sram_oe_n <= 1'b1;
                    ack_r       <= 1'b1;
                    state_r     <= S_ACK;
                end
                S_ACK: begin
                    if (!cur_req) begin
                        ack_r   <= 1'b0;
                        state_r <= S_IDLE;
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE && (rec.req || play.req)) begin
            o_sram_addr  <= pick_play ? play.addr : rec.addr;
            o_sram_wdata <= pick_play ? play.wdata : rec.wdata;
        end
        if (state_r == S_STROBE && !o_sram_oe_n) begin
            rdata_r <= i_sram_rdata;   // end of the oe_n cycle
        end
    end

    a_one_client : assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        !(rec.req && play.req)
    ) else $error("both memory clients request at once");

endmodule

`default_nettype wire

//--- rtl/xport_if.sv
`timescale 1ns/1ps
`default_nettype none

interface xport_if
    import aud_pkg::*;
();

    logic              start;   // one-cycle pulses from the controller
    logic              pause;   // toggles paused and running
    logic              stop;
    logic              active;
    logic [ADDR_W-1:0] count;   // words done since last start

    modport controller (
        output start, pause, stop,
        input  active, count
    );

    modport engine (
        input  start, pause, stop,
        output active, count
    );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_aud_top -f sim.f -o tb_aud_top \
    && ./obj_dir/tb_aud_top | tee /dev/stderr | grep -qx "all tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim.f
rtl/aud_pkg.sv
rtl/mem_req_if.sv
rtl/xport_if.sv
rtl/aud_recorder.sv
rtl/aud_player.sv
rtl/sram_port.sv
rtl/aud_ctrl.sv
rtl/aud_top.sv
verification/aud_tb_models.sv
verification/tb_aud_top.sv

//--- verification/aud_tb_models.sv
`timescale 1ns/1ps
`default_nettype none

// codec ADC side with 32 bit clocks per frame and data in the left slot only
module codec_model (
    input  logic i_clk,
    output logic o_lrclk,
    output logic o_adcdat,
    output int   o_pos
);

    logic [15:0] sent_q [$];   // samples in the order they went out
    logic [15:0] sample;
    logic [15:0] shreg;

    initial begin
        void'($urandom(95));
        o_lrclk  = 1'b1;
        o_adcdat = 1'b0;
        o_pos    = 31;
        sample   = '0;
        shreg    = '0;
        forever begin
            @(posedge i_clk);
            #2;
            o_pos = (o_pos == 31) ? 0 : o_pos + 1;
            if (o_pos == 0) begin
                sample = 16'($urandom);
                sent_q.push_back(sample);
                shreg = sample;
            end
            o_lrclk = (o_pos >= 16);   // low half is the left slot
            if (o_pos >= 1 && o_pos <= 16) begin
                o_adcdat = shreg[15];   // msb one clock after the lr edge
                shreg    = {shreg[14:0], 1'b0};
            end else begin
                o_adcdat = 1'b0;
            end
        end
    end

endmodule

module sram_model (
    input  logic        i_clk,
    input  logic [19:0] i_addr,
    input  logic [15:0] i_wdata,
    input  logic        i_we_n,
    input  logic        i_oe_n,
    output logic [15:0] o_rdata
);

    logic [15:0] mem [0:63];

    always @(posedge i_clk) begin
        if (!i_we_n) begin
            mem[i_addr[5:0]] <= i_wdata;   // end of the we_n low cycle
        end
    end

    assign o_rdata = i_oe_n ? 16'h0000 : mem[i_addr[5:0]];

endmodule

`default_nettype wire

//--- verification/tb_aud_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aud_top
    import aud_pkg::*;
();

    localparam int DEPTH_TB   = 32;
    localparam int FRAME_CYC  = 32;
    localparam int MAX_FRAMES = 40;
    localparam int N_TESTS    = 5;
    localparam int LIMIT_CYC  = N_TESTS * MAX_FRAMES * FRAME_CYC * 2;

    logic                clk;
    logic                rst_n;   // high while in reset
    logic                lrclk;
    logic                adcdat;
    logic                dacdat;
    logic [ADDR_W-1:0]   sram_addr;
    logic [SAMPLE_W-1:0] sram_wdata;
    logic [SAMPLE_W-1:0] sram_rdata;
    logic                sram_we_n;
    logic                sram_oe_n;
    logic                key_rec;
    logic                key_play;
    logic                key_pause;
    logic                key_stop;
    logic                recording;
    logic                playing;
    logic                paused;
    logic [ADDR_W-1:0]   rec_len;
    int                  codec_pos;
    int                  err_cnt    = 0;
    int                  fail_tests = 0;
    int                  cycle_cnt  = 0;
    logic [15:0]         exp_q [$];   // samples that should land in the SRAM

    codec_model u_codec (
        .i_clk    (clk),
        .o_lrclk  (lrclk),
        .o_adcdat (adcdat),
        .o_pos    (codec_pos)
    );

    sram_model u_sram (
        .i_clk   (clk),
        .i_addr  (sram_addr),
        .i_wdata (sram_wdata),
        .i_we_n  (sram_we_n),
        .i_oe_n  (sram_oe_n),
        .o_rdata (sram_rdata)
    );

    aud_top #(
        .DEPTH(DEPTH_TB)
    ) u_dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_adclrck    (lrclk),
        .i_adcdat     (adcdat),
        .i_daclrck    (lrclk),
        .o_dacdat     (dacdat),
        .o_sram_addr  (sram_addr),
        .o_sram_wdata (sram_wdata),
        .i_sram_rdata (sram_rdata),
        .o_sram_we_n  (sram_we_n),
        .o_sram_oe_n  (sram_oe_n),
        .i_key_rec    (key_rec),
        .i_key_play   (key_play),
        .i_key_pause  (key_pause),
        .i_key_stop   (key_stop),
        .o_recording  (recording),
        .o_playing    (playing),
        .o_paused     (paused),
        .o_rec_len    (rec_len)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > LIMIT_CYC) begin
            $display("timeout, run still busy after %0d cycles", LIMIT_CYC);
            $display("tests failed");
            $finish;
        end
    end

    task automatic fail_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        err_cnt++;
    endtask

    task automatic fail_msg(input string what);
        $display("ERROR %s", what);
        err_cnt++;
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s test: ok", name);
        end else begin
            $display("%s test: %0d errors", name, err_cnt - errs_before);
            fail_tests++;
        end
    endtask

    // returns at the drive point of frame position p
    task automatic wait_pos(input int p);
        do begin
            @(posedge clk);
        end while (codec_pos != (p + FRAME_CYC - 1) % FRAME_CYC);
        #2;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic press_key(input logic [3:0] keys);   // {rec, play, pause, stop}
        {key_rec, key_play, key_pause, key_stop} = keys;
        @(posedge clk);
        #2;
        {key_rec, key_play, key_pause, key_stop} = 4'b0000;
    endtask

    task automatic start_record();
        exp_q.delete();
        wait_pos(2);   // first captured frame is the next one
        press_key(4'b1000);
        if (recording !== 1'b1) fail_val("o_recording", recording, 1);
    endtask

    task automatic pass_frames(input int n);
        repeat (n) begin
            wait_pos(1);
            if (!paused) begin
                exp_q.push_back(u_codec.sent_q[$]);
            end
        end
        wait_pos(24);   // write of the last frame is done here
    endtask

    task automatic check_rec();
        if (rec_len !== ADDR_W'(exp_q.size())) fail_val("o_rec_len", rec_len, exp_q.size());
        foreach (exp_q[i]) begin
            if (u_sram.mem[i] !== exp_q[i]) begin
                fail_val($sformatf("sram word %0d", i), u_sram.mem[i], exp_q[i]);
            end
        end
    endtask

    task automatic grab_word(output logic [15:0] word);
        do begin
            @(negedge clk);
        end while (codec_pos != 1);
        word = {15'b0, dacdat};
        repeat (15) begin
            @(negedge clk);
            word = {word[14:0], dacdat};
        end
    endtask

    task automatic test_idle();
        int errs;
        errs = err_cnt;
        if ({recording, playing, paused} !== 3'b000) begin
            fail_val("{o_recording,o_playing,o_paused}", {recording, playing, paused}, 0);
        end
        if (rec_len !== '0) fail_val("o_rec_len", rec_len, 0);
        if (sram_we_n !== 1'b1) fail_val("o_sram_we_n", sram_we_n, 1);
        if (sram_oe_n !== 1'b1) fail_val("o_sram_oe_n", sram_oe_n, 1);
        if (dacdat !== 1'b0) fail_val("o_dacdat", dacdat, 0);
        press_key(4'b0001);
        press_key(4'b0010);
        if ({recording, playing, paused} !== 3'b000) begin
            fail_val("{o_recording,o_playing,o_paused}", {recording, playing, paused}, 0);
        end
        start_record();
        press_key(4'b0100);   // play and record are ignored while recording
        press_key(4'b1000);
        if ({recording, playing, paused} !== 3'b100) begin
            fail_val("{o_recording,o_playing,o_paused}", {recording, playing, paused}, 4);
        end
        press_key(4'b0001);
        if (recording !== 1'b0) fail_val("o_recording", recording, 0);
        end_test("idle", errs);
    endtask

    task automatic test_record();
        int errs;
        errs = err_cnt;
        start_record();
        pass_frames(10);
        press_key(4'b0001);
        wait_cycles(3);
        if (recording !== 1'b0) fail_val("o_recording", recording, 0);
        check_rec();
        end_test("record", errs);
    endtask

    task automatic test_play();
        int          errs;
        int          n;
        int          k;
        logic [15:0] word;
        errs = err_cnt;
        n    = int'(rec_len);
        if (n != 10) fail_val("o_rec_len", rec_len, 10);
        wait_pos(2);
        press_key(4'b0100);
        if (playing !== 1'b1) fail_val("o_playing", playing, 1);
        for (int i = 0; i < n; i++) begin
            grab_word(word);
            if (word !== u_sram.mem[i]) begin
                fail_val($sformatf("o_dacdat word %0d", i), word, u_sram.mem[i]);
            end
            if (playing !== 1'b1) fail_msg($sformatf("playback ended before word %0d", i));
        end
        k = 0;
        while (playing === 1'b1 && k < 8) begin
            @(negedge clk);
            k++;
        end
        if (playing !== 1'b0) fail_msg("playback still running after the last word");
        end_test("play", errs);
    endtask

    task automatic test_pause();
        int errs;
        errs = err_cnt;
        start_record();
        pass_frames(3);
        press_key(4'b0010);
        if (paused !== 1'b1) fail_val("o_paused", paused, 1);
        pass_frames(3);   // these frames are dropped
        press_key(4'b0010);
        if (paused !== 1'b0) fail_val("o_paused", paused, 0);
        pass_frames(3);
        press_key(4'b0001);
        wait_cycles(3);
        if (exp_q.size() != 6) fail_msg("pause did not hold for three frames");
        check_rec();
        end_test("pause", errs);
    endtask

    task automatic test_full();
        int errs;
        errs = err_cnt;
        start_record();
        pass_frames(DEPTH_TB - 1);
        if (recording !== 1'b1) fail_msg("recording ended before the memory was full");
        pass_frames(1);
        if (recording !== 1'b0) fail_msg("recording kept running with a full memory");
        if (rec_len !== ADDR_W'(DEPTH_TB)) fail_val("o_rec_len", rec_len, DEPTH_TB);
        check_rec();
        end_test("full", errs);
    endtask

    initial begin
        rst_n     = 1'b1;
        key_rec   = 1'b0;
        key_play  = 1'b0;
        key_pause = 1'b0;
        key_stop  = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b0;
        test_idle();
        test_record();
        test_play();
        test_pause();
        test_full();
        $display("summary: %0d of %0d tests ok, %0d check errors",
                 N_TESTS - fail_tests, N_TESTS, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
